// ==== verification/sdram_testdata.txt ====
// op (00 write, 01 read, 02 wait for refresh), address {row, bank, col},
// write data, expected read data
00_001510_11111111_00000000
01_001510_00000000_11111111
00_001520_22222222_00000000
01_001520_00000000_22222222
00_048d34_33333333_00000000
01_001510_00000000_11111111
01_048d34_00000000_33333333
00_7ffeff_44444444_00000000
00_02a801_55555555_00000000
00_100380_66666666_00000000
01_7ffeff_00000000_44444444
02_000000_00000000_00000000
01_02a801_00000000_55555555
01_100380_00000000_66666666
01_048d34_00000000_33333333
00_001510_aaaa5555_00000000
01_001510_00000000_aaaa5555
01_001520_00000000_22222222

// ==== files.f ====
hw/sdram_pkg.sv
hw/ctrl_pkg.sv
hw/request_port.sv
hw/refresh_timer.sv
hw/bank_tracker.sv
hw/cmd_sequencer.sv
hw/sdram_controller.sv
verification/tb_clock.sv
verification/sdram_controller_tb.sv

// ==== Bender.yml ====
package:
  name: sdram_controller

sources:
  - hw/sdram_pkg.sv
  - hw/ctrl_pkg.sv
  - hw/request_port.sv
  - hw/refresh_timer.sv
  - hw/bank_tracker.sv
  - hw/cmd_sequencer.sv
  - hw/sdram_controller.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/sdram_controller_tb.sv

// ==== verification/sdram_controller_tb.sv ====
// SDRAM controller testbench
`timescale 1ns/10ps
`default_nettype none

module sdram_controller_tb
    import sdram_pkg::*;
    import ctrl_pkg::*;
();

    localparam int unsigned max_lines       = 64;
    localparam int unsigned cycles_per_line = 2000;
    localparam int unsigned base_cycles     = 5000;
    localparam int unsigned refresh_slack   = 20;
    localparam int unsigned drive_delay     = 1;
    localparam int unsigned key_w           = bank_w + row_w + col_w;
    localparam string       data_file       = "verification/sdram_testdata.txt";

    typedef enum logic [7:0] {
        op_write        = 8'h00,
        op_read         = 8'h01,
        op_refresh_wait = 8'h02,
        op_end          = 8'hff
    } test_op_e;

    // one line of the data file
    typedef struct packed {
        test_op_e          op;
        logic [23:0]       addr;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] expected;
    } test_line_t;

    logic              clk;
    logic              rst;
    logic              req;
    user_req_t         req_data;
    logic [data_w-1:0] sdram_dqi = '0;
    logic              ack;
    logic              rd_valid;
    logic [data_w-1:0] rd_data;
    logic              sdram_cke;
    logic              sdram_cs;
    logic              sdram_ras;
    logic              sdram_cas;
    logic              sdram_we;
    logic [bank_w-1:0] sdram_ba;
    logic [row_w-1:0]  sdram_a;
    logic [data_w-1:0] sdram_dqo;
    logic              sdram_dq_oe;

    logic [95:0]       raw_lines [max_lines];
    int unsigned       line_count   = 0;
    logic              data_loaded  = 1'b0;
    int unsigned       error_count  = 0;
    int unsigned       tests_run    = 0;
    int unsigned       tests_bad    = 0;

    // command log and counters filled by the monitor
    sdram_bus_t        cmd_log [$];
    sdram_bus_t        seen;
    int unsigned       access_count  = 0;
    int unsigned       read_count    = 0;
    int unsigned       refresh_count = 0;
    int unsigned       cycles_since_refresh = 0;
    logic [data_w-1:0] last_rd_data;
    logic              ack_prev;
    logic              req_prev;

    // expected open rows, kept from the access rules
    logic [num_banks-1:0] exp_open = '0;
    logic [row_w-1:0]     exp_row [num_banks];

    // memory model state
    logic [key_w-1:0]     mem_keys [$];
    logic [data_w-1:0]    mem_words [$];
    logic [row_w-1:0]     model_row [num_banks] = '{default: '0};
    sdram_cmd_e           model_cmd;
    logic [key_w-1:0]     model_key;
    logic [key_w-1:0]     read_key;
    int unsigned          read_age = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    sdram_controller dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_data    (req_data),
        .sdram_dqi   (sdram_dqi),
        .ack         (ack),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
    endtask

    // unwritten words read back a pattern of their own address
    function automatic logic [data_w-1:0] read_word(input logic [key_w-1:0] key);
        logic [data_w-1:0] word;
        word = {~key[8:0], key};
        foreach (mem_keys[i]) begin
            if (mem_keys[i] == key) begin
                word = mem_words[i];
            end
        end
        return word;
    endfunction

    task automatic store_word(input logic [key_w-1:0] key, input logic [data_w-1:0] word);
        int found;
        found = -1;
        foreach (mem_keys[i]) begin
            if (mem_keys[i] == key) begin
                found = i;
            end
        end
        if (found < 0) begin
            mem_keys.push_back(key);
            mem_words.push_back(word);
        end else begin
            mem_words[found] = word;
        end
    endtask

    // SDRAM model, commands sampled at the clock edge like the real part
    always @(posedge clk) begin
        model_cmd = sdram_cmd_e'({sdram_cs, sdram_ras, sdram_cas, sdram_we});
        model_key = {sdram_ba, model_row[sdram_ba], col_w'(sdram_a >> col_shift)};
        // data window from the second to the fourth edge after READ
        if (read_age == 1) begin
            sdram_dqi <= #drive_delay read_word(read_key);
        end
        if (read_age == 3) begin
            sdram_dqi <= #drive_delay '0;
        end
        if (read_age != 0) begin
            read_age = (read_age == 3) ? 0 : read_age + 1;
        end
        case (model_cmd)
            cmd_active: model_row[sdram_ba] = sdram_a;
            cmd_write:  store_word(model_key, sdram_dqo);
            cmd_read: begin
                read_key = model_key;
                read_age = 1;
            end
            default: ;
        endcase
    end

    // monitor, mid cycle where every output is settled
    always @(negedge clk) begin
        if (rst) begin
            ack_prev             = 1'b0;
            req_prev             = 1'b0;
            cycles_since_refresh = 0;
        end else begin
            seen.cmd = sdram_cmd_e'({sdram_cs, sdram_ras, sdram_cas, sdram_we});
            seen.ba  = sdram_ba;
            seen.a   = sdram_a;
            if (seen.cmd != cmd_nop && seen.cmd != cmd_unselected) begin
                cmd_log.push_back(seen);
            end
            if (seen.cmd == cmd_read || seen.cmd == cmd_write) begin
                access_count++;
            end
            check_value("sdram_dq_oe", sdram_dq_oe, seen.cmd == cmd_write);
            cycles_since_refresh++;
            if (seen.cmd == cmd_precharge && seen.a[a10_bit]) begin
                refresh_count++;
                cycles_since_refresh = 0;
            end else if (cycles_since_refresh == refresh_interval + refresh_slack + 1) begin
                report_problem("no refresh was started within the refresh interval");
            end
            if (rd_valid) begin
                last_rd_data = rd_data;
                read_count++;
            end
            if (ack && !ack_prev && !req_prev) begin
                report_problem("ack rose while req was low");
            end
            if (!ack && ack_prev && req_prev) begin
                report_problem("ack fell while req was still high");
            end
            ack_prev = ack;
            req_prev = req;
        end
    end

    task automatic send_request(input logic write, input sdram_addr_t addr,
                                input logic [data_w-1:0] wdata);
        @(posedge clk);
        #drive_delay;
        req            = 1'b1;
        req_data.write = write;
        req_data.addr  = addr;
        req_data.wdata = wdata;
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(posedge clk);
        #drive_delay;
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic expect_command(input sdram_cmd_e cmd, input logic [bank_w-1:0] ba,
                                  input logic [row_w-1:0] a, input logic [row_w-1:0] a_mask,
                                  input logic use_ba);
        sdram_bus_t got;
        if (cmd_log.size() == 0) begin
            report_problem($sformatf("expected a %s command but none was issued", cmd.name()));
        end else begin
            got = cmd_log.pop_front();
            check_value("sdram command", got.cmd, cmd);
            if (got.cmd == cmd) begin
                if (use_ba) begin
                    check_value("sdram_ba", got.ba, ba);
                end
                check_value("sdram_a", got.a & a_mask, a & a_mask);
            end
        end
    endtask

    // command order for one access, from the open-row rules
    task automatic check_access_commands(input sdram_addr_t addr, input logic write);
        sdram_cmd_e access_cmd;
        access_cmd = write ? cmd_write : cmd_read;
        // a refresh taken first closes every bank
        while (cmd_log.size() > 0 && cmd_log[0].cmd == cmd_precharge
               && cmd_log[0].a[a10_bit]) begin
            void'(cmd_log.pop_front());
            expect_command(cmd_refresh, '0, '0, '0, 1'b0);
            exp_open = '0;
        end
        if (exp_open[addr.bank] && exp_row[addr.bank] != addr.row) begin
            expect_command(cmd_precharge, addr.bank, '0, row_w'(1) << a10_bit, 1'b1);
            exp_open[addr.bank] = 1'b0;
        end
        if (!exp_open[addr.bank]) begin
            expect_command(cmd_active, addr.bank, addr.row, '1, 1'b1);
            exp_open[addr.bank] = 1'b1;
            exp_row[addr.bank]  = addr.row;
        end
        expect_command(access_cmd, addr.bank, row_w'(addr.col) << col_shift, '1, 1'b1);
    endtask

    task automatic close_test(input int unsigned num, input string label,
                              input int unsigned errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", num, label);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, label, error_count - errs_before);
        end
    endtask

    task automatic run_line(input int unsigned num, input test_line_t line);
        int unsigned errs_before;
        int unsigned reads_before;
        int unsigned accesses_before;
        int unsigned refreshes_before;
        sdram_addr_t addr;
        errs_before      = error_count;
        reads_before     = read_count;
        accesses_before  = access_count;
        refreshes_before = refresh_count;
        addr             = line.addr[key_w-1:0];
        case (line.op)
            op_write, op_read: begin
                send_request(line.op == op_write, addr, line.wdata);
                if (line.op == op_write) begin
                    wait (access_count > accesses_before);
                end else begin
                    wait (read_count > reads_before);
                    check_value("rd_data", last_rd_data, line.expected);
                end
                // one more monitor pass, then look once it has finished
                @(negedge clk);
                #drive_delay;
                check_value("rd_valid pulses", read_count - reads_before, line.op == op_read);
                check_access_commands(addr, line.op == op_write);
                repeat ($urandom_range(6, 0)) @(posedge clk);
            end
            // the next request then arrives while the refresh runs
            op_refresh_wait: wait (refresh_count > refreshes_before);
            default: report_problem($sformatf("unknown operation %h in the data file", line.op));
        endcase
        close_test(num, $sformatf("%s %06h", line.op.name(), line.addr), errs_before);
    endtask

    initial begin
        int unsigned seed;
        int unsigned n;
        int unsigned errs_before;
        req      = 1'b0;
        req_data = '0;
        seed     = $urandom(99);
        for (n = 0; n < max_lines; n++) begin
            raw_lines[n] = '1;
        end
        $readmemh(data_file, raw_lines);
        while (line_count < max_lines && raw_lines[line_count][95:88] != op_end) begin
            line_count++;
        end
        data_loaded = 1'b1;

        // outputs while reset is held
        errs_before = error_count;
        repeat (2) @(negedge clk);
        check_value("ack", ack, 1'b0);
        check_value("rd_valid", rd_valid, 1'b0);
        check_value("command pins", {sdram_cs, sdram_ras, sdram_cas, sdram_we}, cmd_nop);
        check_value("sdram_dq_oe", sdram_dq_oe, 1'b0);
        while (rst) @(negedge clk);
        n = 0;
        while (!sdram_cke && n < 2) begin
            @(negedge clk);
            n++;
        end
        check_value("sdram_cke", sdram_cke, 1'b1);
        close_test(0, "reset", errs_before);

        if (line_count == 0) begin
            report_problem("the data file holds no operations");
        end
        for (n = 0; n < line_count; n++) begin
            run_line(n + 1, test_line_t'(raw_lines[n]));
        end

        $display("%0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, error_count);
        if (error_count == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog scaled to the number of operations
    initial begin
        wait (data_loaded);
        repeat (line_count * cycles_per_line + base_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 line_count * cycles_per_line + base_cycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int unsigned half_period  = 2;
    localparam int unsigned reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/sdram_controller.sv ====
// SDRAM controller top
`timescale 1ns/10ps
`default_nettype none

module sdram_controller
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req,
    input  wire user_req_t         req_data,
    input  wire logic [data_w-1:0] sdram_dqi,
    output logic                   ack,
    output logic                   rd_valid,
    output logic [data_w-1:0]      rd_data,
    output logic                   sdram_cke,
    output logic                   sdram_cs,
    output logic                   sdram_ras,
    output logic                   sdram_cas,
    output logic                   sdram_we,
    output logic [bank_w-1:0]      sdram_ba,
    output logic [row_w-1:0]       sdram_a,
    output logic [data_w-1:0]      sdram_dqo,
    output logic                   sdram_dq_oe
);

    logic        pending;
    user_req_t   held;
    logic        take;
    logic        refresh_due;
    logic        refresh_start;
    sdram_addr_t lookup_addr;
    row_lookup_e lookup;
    logic        open_row;
    logic        close_bank;
    logic        close_all;
    sdram_bus_t  pins;

    request_port u_port (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .take     (take),
        .ack      (ack),
        .pending  (pending),
        .held     (held)
    );

    refresh_timer u_refresh (
        .clk           (clk),
        .rst           (rst),
        .refresh_start (refresh_start),
        .refresh_due   (refresh_due)
    );

    bank_tracker u_banks (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .open_row    (open_row),
        .close_bank  (close_bank),
        .close_all   (close_all),
        .lookup      (lookup)
    );

    cmd_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .pending       (pending),
        .held          (held),
        .refresh_due   (refresh_due),
        .lookup        (lookup),
        .sdram_dqi     (sdram_dqi),
        .take          (take),
        .refresh_start (refresh_start),
        .open_row      (open_row),
        .close_bank    (close_bank),
        .close_all     (close_all),
        .lookup_addr   (lookup_addr),
        .pins          (pins),
        .cke           (sdram_cke),
        .sdram_dqo     (sdram_dqo),
        .dq_oe         (sdram_dq_oe),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

    // command code order is cs, ras, cas, we
    assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = pins.cmd;
    assign sdram_ba = pins.ba;
    assign sdram_a  = pins.a;

endmodule

`default_nettype wire

// ==== hw/cmd_sequencer.sv ====
// SDRAM command sequencer
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              pending,
    input  wire user_req_t         held,
    input  wire logic              refresh_due,
    input  wire row_lookup_e       lookup,
    input  wire logic [data_w-1:0] sdram_dqi,
    output logic                   take,
    output logic                   refresh_start,
    output logic                   open_row,
    output logic                   close_bank,
    output logic                   close_all,
    output sdram_addr_t            lookup_addr,
    output sdram_bus_t             pins,
    output logic                   cke,
    output logic [data_w-1:0]      sdram_dqo,
    output logic                   dq_oe,
    output logic                   rd_valid,
    output logic [data_w-1:0]      rd_data
);

    seq_state_e          state_q, state_d;
    seq_state_e          ret_q, ret_d;
    logic [delay_w-1:0]  delay_q, delay_d;
    logic                ref_q, ref_d;
    user_req_t           work_q, work_d;
    sdram_bus_t          pins_q, pins_d;
    logic                cke_q, cke_d;
    logic [data_w-1:0]   dqo_q, dqo_d;
    logic                oe_q, oe_d;
    logic [data_w-1:0]   rd_data_q, rd_data_d;
    logic                rd_valid_q, rd_valid_d;
    logic [row_w-1:0]    col_pins;

    // the queued request is classified while still idle
    assign lookup_addr = (state_q == st_idle) ? held.addr : work_q.addr;

    // column sits above the byte lanes, a10 stays low
    assign col_pins = row_w'(work_q.addr.col) << col_shift;

    always_comb begin
        state_d       = state_q;
        ret_d         = ret_q;
        delay_d       = delay_q;
        ref_d         = ref_q;
        work_d        = work_q;
        cke_d         = cke_q;
        pins_d.cmd    = cmd_nop;
        pins_d.ba     = '0;
        pins_d.a      = '0;
        dqo_d         = dqo_q;
        oe_d          = 1'b0;
        rd_data_d     = rd_data_q;
        rd_valid_d    = 1'b0;
        take          = 1'b0;
        refresh_start = 1'b0;
        open_row      = 1'b0;
        close_bank    = 1'b0;
        close_all     = 1'b0;

        case (state_q)
            st_init: begin
                // power-up wait and mode register load are not needed
                cke_d   = 1'b1;
                state_d = st_idle;
            end
            st_idle: begin
                if (refresh_due) begin
                    refresh_start = 1'b1;
                    ref_d         = 1'b1;
                    state_d       = st_precharge;
                end else if (pending) begin
                    take   = 1'b1;
                    work_d = held;
                    case (lookup)
                        row_hit:     state_d = held.write ? st_write : st_read;
                        bank_closed: state_d = st_activate;
                        default:     state_d = st_precharge;
                    endcase
                end
            end
            st_precharge: begin
                pins_d.cmd       = cmd_precharge;
                pins_d.ba        = work_q.addr.bank;
                pins_d.a[a10_bit] = ref_q;
                close_bank       = 1'b1;
                close_all        = ref_q;
                delay_d          = delay_w'(t_pre);
                ret_d            = ref_q ? st_idle : st_activate;
                state_d          = st_wait_delay;
            end
            st_activate: begin
                pins_d.cmd = cmd_active;
                pins_d.ba  = work_q.addr.bank;
                pins_d.a   = work_q.addr.row;
                open_row   = 1'b1;
                delay_d    = delay_w'(t_act);
                ret_d      = work_q.write ? st_write : st_read;
                state_d    = st_wait_delay;
            end
            st_read: begin
                pins_d.cmd = cmd_read;
                pins_d.ba  = work_q.addr.bank;
                pins_d.a   = col_pins;
                // two wait cycles put the capture on the third edge
                delay_d    = delay_w'(cas_latency - 2);
                ret_d      = st_read_capture;
                state_d    = st_wait_delay;
            end
            st_write: begin
                pins_d.cmd = cmd_write;
                pins_d.ba  = work_q.addr.bank;
                pins_d.a   = col_pins;
                dqo_d      = work_q.wdata;
                oe_d       = 1'b1;
                state_d    = st_idle;
            end
            st_wait_delay: begin
                delay_d = delay_q - 1'b1;
                if (delay_q == '0) begin
                    if (ref_q) begin
                        // all banks closed, now the auto-refresh itself
                        pins_d.cmd = cmd_refresh;
                        delay_d    = delay_w'(t_ref);
                        ref_d      = 1'b0;
                    end else begin
                        state_d = ret_q;
                    end
                end
            end
            st_read_capture: begin
                rd_data_d  = sdram_dqi;
                rd_valid_d = 1'b1;
                state_d    = st_idle;
            end
            default: state_d = st_init;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_init;
            ret_q      <= st_idle;
            delay_q    <= '0;
            ref_q      <= 1'b0;
            cke_q      <= 1'b0;
            pins_q     <= '{cmd: cmd_nop, ba: '0, a: '0};
            oe_q       <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            ret_q      <= ret_d;
            delay_q    <= delay_d;
            ref_q      <= ref_d;
            cke_q      <= cke_d;
            pins_q     <= pins_d;
            oe_q       <= oe_d;
            rd_valid_q <= rd_valid_d;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        work_q    <= work_d;
        dqo_q     <= dqo_d;
        rd_data_q <= rd_data_d;
    end

    assign pins      = pins_q;
    assign cke       = cke_q;
    assign sdram_dqo = dqo_q;
    assign dq_oe     = oe_q;
    assign rd_valid  = rd_valid_q;
    assign rd_data   = rd_data_q;

    a_oe_with_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> pins.cmd == cmd_write);

    a_access_on_open_row: assert property (@(posedge clk) disable iff (rst)
        (state_q == st_read || state_q == st_write) |-> lookup == row_hit);

endmodule

`default_nettype wire

// ==== hw/bank_tracker.sv ====
// Open row tracker
`timescale 1ns/10ps
`default_nettype none

module bank_tracker
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire sdram_addr_t lookup_addr,
    input  wire logic        open_row,
    input  wire logic        close_bank,
    input  wire logic        close_all,
    output row_lookup_e      lookup
);

    logic [num_banks-1:0] open_q;
    logic [row_w-1:0]     row_q [num_banks];

    // open flags per bank
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (close_bank) begin
            if (close_all) begin
                open_q <= '0;
            end else begin
                open_q[lookup_addr.bank] <= 1'b0;
            end
        end else if (open_row) begin
            open_q[lookup_addr.bank] <= 1'b1;
        end
    end

    // row number is only meaningful while the flag is set
    always_ff @(posedge clk) begin
        if (open_row) begin
            row_q[lookup_addr.bank] <= lookup_addr.row;
        end
    end

    always_comb begin
        if (!open_q[lookup_addr.bank]) begin
            lookup = bank_closed;
        end else if (row_q[lookup_addr.bank] == lookup_addr.row) begin
            lookup = row_hit;
        end else begin
            lookup = row_conflict;
        end
    end

endmodule

`default_nettype wire

// ==== hw/refresh_timer.sv ====
// Refresh interval timer
`timescale 1ns/10ps
`default_nettype none

module refresh_timer
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic refresh_start,
    output logic      refresh_due
);

    logic [refresh_cnt_w-1:0] count_q;
    logic                     due_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            due_q   <= 1'b0;
        end else if (refresh_start) begin
            // refresh taken, restart the interval
            count_q <= '0;
            due_q   <= 1'b0;
        end else if (count_q == refresh_cnt_w'(refresh_interval - 1)) begin
            count_q <= '0;
            due_q   <= 1'b1;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign refresh_due = due_q;

    a_start_when_due: assert property (@(posedge clk) disable iff (rst)
        refresh_start |-> refresh_due);

endmodule

`default_nettype wire

// ==== hw/request_port.sv ====
// User request port
`timescale 1ns/10ps
`default_nettype none

module request_port
    import ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      req,
    input  wire user_req_t req_data,
    input  wire logic      take,
    output logic           ack,
    output logic           pending,
    output user_req_t      held
);

    logic      ack_q;
    logic      full_q;
    user_req_t held_q;
    logic      capture;

    // new request only once the previous handshake has closed
    assign capture = req && !ack_q && !full_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            full_q <= 1'b0;
        end else begin
            if (capture) begin
                ack_q <= 1'b1;
            end else if (!req) begin
                ack_q <= 1'b0;
            end
            if (capture) begin
                full_q <= 1'b1;
            end else if (take) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_q <= req_data;
        end
    end

    assign ack     = ack_q;
    assign pending = full_q;
    assign held    = held_q;

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    a_take_when_pending: assert property (@(posedge clk) disable iff (rst)
        take |-> pending);

endmodule

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
// SDRAM controller definitions
`default_nettype none

package ctrl_pkg;

    import sdram_pkg::*;

    // wide enough for the longest post-command wait
    localparam int unsigned delay_w = $clog2(t_ref + 1);

    // refresh interval counter width
    localparam int unsigned refresh_cnt_w = $clog2(refresh_interval);

    // one queued user access
    typedef struct packed {
        logic              write;
        sdram_addr_t       addr;
        logic [data_w-1:0] wdata;
    } user_req_t;

    typedef enum logic [3:0] {
        st_init,
        st_idle,
        st_precharge,
        st_activate,
        st_read,
        st_write,
        st_wait_delay,
        st_read_capture
    } seq_state_e;

    // open-row table result for the looked-up address
    typedef enum logic [1:0] {
        row_hit,
        bank_closed,
        row_conflict
    } row_lookup_e;

endpackage

`default_nettype wire

// ==== hw/sdram_pkg.sv ====
// SDRAM device definitions
`default_nettype none

package sdram_pkg;

    // device geometry
    localparam int unsigned num_banks = 4;
    localparam int unsigned row_w     = 13;
    localparam int unsigned bank_w    = 2;
    localparam int unsigned col_w     = 8;
    localparam int unsigned data_w    = 32;

    // delays after a command, counted as extra cycles
    // 3-3-3 part, so each gap below is the value plus one
    localparam int unsigned t_pre       = 2;
    localparam int unsigned t_act       = 2;
    localparam int unsigned t_ref       = 6;
    localparam int unsigned cas_latency = 3;

    // cycles between auto-refresh requests
    localparam int unsigned refresh_interval = 752;

    // address pin layout
    localparam int unsigned a10_bit   = 10;
    localparam int unsigned col_shift = 2;

    // {cs, ras, cas, we}
    typedef enum logic [3:0] {
        cmd_unselected = 4'b1000,
        cmd_nop        = 4'b0111,
        cmd_active     = 4'b0011,
        cmd_read       = 4'b0101,
        cmd_write      = 4'b0100,
        cmd_precharge  = 4'b0010,
        cmd_refresh    = 4'b0001
    } sdram_cmd_e;

    // user address split, row on top and column at the bottom
    typedef struct packed {
        logic [row_w-1:0]  row;
        logic [bank_w-1:0] bank;
        logic [col_w-1:0]  col;
    } sdram_addr_t;

    // one registered command as seen on the pins
    typedef struct packed {
        sdram_cmd_e        cmd;
        logic [bank_w-1:0] ba;
        logic [row_w-1:0]  a;
    } sdram_bus_t;

endpackage

`default_nettype wire
